//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_PASS_B = 3'd4
	} alu_op_e;

	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

	// immediate formats, sign extended to 32 bits
	function automatic logic [31:0] imm_i(input logic [31:0] inst);
		return {{20{inst[31]}}, inst[31:20]};
	endfunction

	function automatic logic [31:0] imm_s(input logic [31:0] inst);
		return {{20{inst[31]}}, inst[31:25], inst[11:7]};
	endfunction

	function automatic logic [31:0] imm_b(input logic [31:0] inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	function automatic logic [31:0] imm_u(input logic [31:0] inst);
		return {inst[31:12], 12'b0};
	endfunction

	function automatic logic [31:0] imm_j(input logic [31:0] inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

	// ifu to idu
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fs_to_ds_t;

	// idu to exu, operands already read
	typedef struct packed {
		logic [31:0]         pc;
		logic [31:0]         src_a;
		logic [31:0]         src_b;
		logic [31:0]         st_data;
		logic [31:0]         imm;
		rv_isa_pkg::alu_op_e alu_op;
		logic [4:0]          rd;
		logic                we;
		logic                is_load;
		logic                is_store;
		logic                is_branch;
		logic                is_bne;
		logic                is_jal;
		logic                is_ebreak;
	} ds_to_es_t;

	// exu to lsu, result doubles as the memory address
	typedef struct packed {
		logic [31:0] result;
		logic [31:0] st_data;
		logic [4:0]  rd;
		logic        we;
		logic        is_load;
		logic        is_store;
		logic        is_ebreak;
	} es_to_ms_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	// in-flight destination seen by the interlock
	typedef struct packed {
		logic       valid;
		logic [4:0] rd;
	} dest_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        we;
	} mem_req_t;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/100ps
module rv_regfile (
	input  logic             clock,
	input  logic             rst_n_i,
	input  logic [4:0]       rs1_i,
	input  logic [4:0]       rs2_i,
	output logic [31:0]      rdata1_o,
	output logic [31:0]      rdata2_o,
	input  rv_core_pkg::wb_t wb_i
);
	import rv_core_pkg::*;

	logic [31:0] regs [1:31];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.rd != 5'd0) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// x0 is zero, same-cycle write is bypassed
	function automatic logic [31:0] read_port(input logic [4:0] rs);
		if (rs == 5'd0) begin
			return '0;
		end else if (wb_i.we && wb_i.rd == rs) begin
			return wb_i.data;
		end
		return regs[rs];
	endfunction

	always_comb begin
		rdata1_o = read_port(rs1_i);
		rdata2_o = read_port(rs2_i);
	end

endmodule

//--- hdl/rv_ifu_stage.sv
`timescale 1ns/100ps
module rv_ifu_stage #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  rv_core_pkg::redirect_t redirect_i,
	input  logic                   halt_i,
	input  logic                   ds_allowin_i,
	output logic                   fs_to_ds_valid_o,
	output rv_core_pkg::fs_to_ds_t fs_to_ds_bus_o,
	output logic                   inst_req_valid_o,
	output logic [31:0]            inst_addr_o,
	input  logic                   inst_req_ready_i,
	input  logic                   inst_rsp_valid_i,
	input  logic [31:0]            inst_rdata_i
);
	import rv_core_pkg::*;

	logic        run_q;
	logic [31:0] pc_q;
	logic        pend_q;
	logic        drop_q;
	logic [31:0] fetch_pc_q;
	logic        out_valid_q;
	fs_to_ds_t   out_bus_q;
	logic        req_fire;

	// fetch only when the output slot is empty or draining this cycle
	assign inst_req_valid_o = run_q && !halt_i && !pend_q && !redirect_i.valid &&
		(!out_valid_q || ds_allowin_i);
	assign inst_addr_o = pc_q;
	assign req_fire = inst_req_valid_o && inst_req_ready_i;
	assign fs_to_ds_valid_o = out_valid_q;
	assign fs_to_ds_bus_o = out_bus_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run_q <= 1'b0;
			pc_q <= RESET_PC;
			pend_q <= 1'b0;
			drop_q <= 1'b0;
			out_valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (redirect_i.valid) begin
				pc_q <= redirect_i.target;
			end else if (req_fire) begin
				pc_q <= pc_q + 32'd4;
			end
			if (req_fire) begin
				pend_q <= 1'b1;
			end else if (inst_rsp_valid_i) begin
				pend_q <= 1'b0;
			end
			// stale fetch still in flight
			if (inst_rsp_valid_i) begin
				drop_q <= 1'b0;
			end else if (redirect_i.valid && pend_q) begin
				drop_q <= 1'b1;
			end
			if (redirect_i.valid) begin
				out_valid_q <= 1'b0;
			end else if (inst_rsp_valid_i && !drop_q) begin
				out_valid_q <= 1'b1;
			end else if (ds_allowin_i) begin
				out_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			fetch_pc_q <= pc_q;
		end
		if (inst_rsp_valid_i) begin
			out_bus_q.pc <= fetch_pc_q;
			out_bus_q.inst <= inst_rdata_i;
		end
	end

	a_addr_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		inst_req_valid_o && !inst_req_ready_i |=> !inst_req_valid_o || $stable(inst_addr_o));

endmodule

//--- hdl/rv_idu_stage.sv
`timescale 1ns/100ps
module rv_idu_stage (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  logic                   fs_to_ds_valid_i,
	input  rv_core_pkg::fs_to_ds_t fs_to_ds_bus_i,
	output logic                   ds_allowin_o,
	output logic                   ds_to_es_valid_o,
	output rv_core_pkg::ds_to_es_t ds_to_es_bus_o,
	input  logic                   es_allowin_i,
	input  rv_core_pkg::dest_t     es_dest_i,
	input  rv_core_pkg::dest_t     ms_dest_i,
	input  rv_core_pkg::wb_t       wb_i,
	input  rv_core_pkg::redirect_t redirect_i
);
	import rv_core_pkg::*;
	import rv_isa_pkg::*;

	logic        ds_valid_q;
	fs_to_ds_t   ds_bus_q;
	logic [31:0] inst;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	logic        use_rs1;
	logic        use_rs2;
	logic        hazard;
	ds_to_es_t   dec;

	assign inst = ds_bus_q.inst;

	rv_regfile u_regfile (
		.clock    (clock       ),
		.rst_n_i  (rst_n_i     ),
		.rs1_i    (inst[19:15] ),
		.rs2_i    (inst[24:20] ),
		.rdata1_o (rdata1      ),
		.rdata2_o (rdata2      ),
		.wb_i     (wb_i        )
	);

	always_comb begin
		dec = '0;
		dec.pc = ds_bus_q.pc;
		dec.src_a = rdata1;
		dec.src_b = rdata2;
		dec.st_data = rdata2;
		dec.alu_op = ALU_ADD;
		dec.rd = inst[11:7];
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode_e'(inst[6:0]))
			OPC_LUI: begin
				dec.src_b = imm_u(inst);
				dec.alu_op = ALU_PASS_B;
				dec.we = 1'b1;
			end
			OPC_OP_IMM: begin
				dec.src_b = imm_i(inst);
				dec.we = 1'b1;
				use_rs1 = 1'b1;
			end
			OPC_OP: begin
				// funct3 picks the op, funct7 bit 5 turns add into sub
				case (inst[14:12])
					3'b110: dec.alu_op = ALU_OR;
					3'b111: dec.alu_op = ALU_AND;
					default: dec.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
				endcase
				dec.we = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			OPC_LOAD: begin
				dec.src_b = imm_i(inst);
				dec.we = 1'b1;
				dec.is_load = 1'b1;
				use_rs1 = 1'b1;
			end
			OPC_STORE: begin
				dec.src_b = imm_s(inst);
				dec.is_store = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			OPC_BRANCH: begin
				dec.imm = imm_b(inst);
				dec.is_branch = 1'b1;
				dec.is_bne = inst[12];
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			OPC_JAL: begin
				dec.imm = imm_j(inst);
				dec.we = 1'b1;
				dec.is_jal = 1'b1;
			end
			OPC_SYSTEM: dec.is_ebreak = (inst == INST_EBREAK);
			default: ;
		endcase
	end

	function automatic logic in_flight(input logic [4:0] rs);
		return rs != 5'd0 && ((es_dest_i.valid && es_dest_i.rd == rs) ||
			(ms_dest_i.valid && ms_dest_i.rd == rs));
	endfunction

	always_comb begin
		hazard = (use_rs1 && in_flight(inst[19:15])) || (use_rs2 && in_flight(inst[24:20]));
	end

	assign ds_allowin_o = !ds_valid_q || (!hazard && es_allowin_i);
	// nothing issues behind a taken branch
	assign ds_to_es_valid_o = ds_valid_q && !hazard && !redirect_i.valid;
	assign ds_to_es_bus_o = dec;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ds_valid_q <= 1'b0;
		end else if (redirect_i.valid) begin
			ds_valid_q <= 1'b0;
		end else if (ds_allowin_o) begin
			ds_valid_q <= fs_to_ds_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (fs_to_ds_valid_i && ds_allowin_o) begin
			ds_bus_q <= fs_to_ds_bus_i;
		end
	end

endmodule

//--- hdl/rv_exu_stage.sv
`timescale 1ns/100ps
module rv_exu_stage (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  logic                   ds_to_es_valid_i,
	input  rv_core_pkg::ds_to_es_t ds_to_es_bus_i,
	output logic                   es_allowin_o,
	input  logic                   ms_allowin_i,
	output logic                   es_to_ms_valid_o,
	output rv_core_pkg::es_to_ms_t es_to_ms_bus_o,
	output rv_core_pkg::dest_t     es_dest_o,
	output rv_core_pkg::redirect_t redirect_o
);
	import rv_core_pkg::*;
	import rv_isa_pkg::*;

	logic        es_valid_q;
	ds_to_es_t   es_bus_q;
	logic [31:0] alu_out;
	logic        taken;

	always_comb begin
		case (es_bus_q.alu_op)
			ALU_SUB: alu_out = es_bus_q.src_a - es_bus_q.src_b;
			ALU_AND: alu_out = es_bus_q.src_a & es_bus_q.src_b;
			ALU_OR: alu_out = es_bus_q.src_a | es_bus_q.src_b;
			ALU_PASS_B: alu_out = es_bus_q.src_b;
			default: alu_out = es_bus_q.src_a + es_bus_q.src_b;
		endcase
	end

	// beq/bne share one compare
	assign taken = es_bus_q.is_jal ||
		(es_bus_q.is_branch && ((es_bus_q.src_a == es_bus_q.src_b) ^ es_bus_q.is_bne));

	assign es_allowin_o = !es_valid_q || ms_allowin_i;
	assign es_to_ms_valid_o = es_valid_q;

	assign es_to_ms_bus_o.result = es_bus_q.is_jal ? es_bus_q.pc + 32'd4 : alu_out;
	assign es_to_ms_bus_o.st_data = es_bus_q.st_data;
	assign es_to_ms_bus_o.rd = es_bus_q.rd;
	assign es_to_ms_bus_o.we = es_bus_q.we;
	assign es_to_ms_bus_o.is_load = es_bus_q.is_load;
	assign es_to_ms_bus_o.is_store = es_bus_q.is_store;
	assign es_to_ms_bus_o.is_ebreak = es_bus_q.is_ebreak;

	assign es_dest_o.valid = es_valid_q && es_bus_q.we;
	assign es_dest_o.rd = es_bus_q.rd;

	// only when the branch moves on, so it fires once
	assign redirect_o.valid = es_valid_q && ms_allowin_i && taken;
	assign redirect_o.target = es_bus_q.pc + es_bus_q.imm;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			es_valid_q <= 1'b0;
		end else if (es_allowin_o) begin
			es_valid_q <= ds_to_es_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (ds_to_es_valid_i && es_allowin_o) begin
			es_bus_q <= ds_to_es_bus_i;
		end
	end

	// the redirecting item leaves and the wrong-path item behind it is held back
	a_redirect_own: assert property (@(posedge clock) disable iff (!rst_n_i)
		redirect_o.valid |-> es_valid_q ##1 !es_valid_q);

endmodule

//--- hdl/rv_lsu_stage.sv
`timescale 1ns/100ps
module rv_lsu_stage (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  logic                   es_to_ms_valid_i,
	input  rv_core_pkg::es_to_ms_t es_to_ms_bus_i,
	output logic                   ms_allowin_o,
	output rv_core_pkg::dest_t     ms_dest_o,
	output rv_core_pkg::wb_t       wb_o,
	output logic                   data_req_valid_o,
	output rv_core_pkg::mem_req_t  data_req_o,
	input  logic                   data_req_ready_i,
	input  logic                   data_rsp_valid_i,
	input  logic [31:0]            data_rdata_i,
	output logic                   halt_o
);
	import rv_core_pkg::*;

	logic      ms_valid_q;
	es_to_ms_t ms_bus_q;
	logic      req_sent_q;
	logic      halt_q;
	logic      mem_op;
	logic      ms_done;

	assign mem_op = ms_bus_q.is_load || ms_bus_q.is_store;
	assign ms_done = !mem_op || (req_sent_q && data_rsp_valid_i);
	// ebreak stays parked so nothing behind it retires
	assign ms_allowin_o = !ms_valid_q || (ms_done && !ms_bus_q.is_ebreak);

	assign data_req_valid_o = ms_valid_q && mem_op && !req_sent_q;
	assign data_req_o.addr = ms_bus_q.result;
	assign data_req_o.wdata = ms_bus_q.st_data;
	assign data_req_o.we = ms_bus_q.is_store;

	assign wb_o.we = ms_valid_q && ms_done && ms_bus_q.we;
	assign wb_o.rd = ms_bus_q.rd;
	assign wb_o.data = ms_bus_q.is_load ? data_rdata_i : ms_bus_q.result;

	// the finishing item is covered by the regfile bypass
	assign ms_dest_o.valid = ms_valid_q && ms_bus_q.we && !ms_done;
	assign ms_dest_o.rd = ms_bus_q.rd;

	assign halt_o = halt_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ms_valid_q <= 1'b0;
			req_sent_q <= 1'b0;
			halt_q <= 1'b0;
		end else begin
			if (ms_allowin_o) begin
				ms_valid_q <= es_to_ms_valid_i;
			end
			if (data_req_valid_o && data_req_ready_i) begin
				req_sent_q <= 1'b1;
			end else if (data_rsp_valid_i) begin
				req_sent_q <= 1'b0;
			end
			if (ms_valid_q && ms_bus_q.is_ebreak) begin
				halt_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (es_to_ms_valid_i && ms_allowin_o) begin
			ms_bus_q <= es_to_ms_bus_i;
		end
	end

	a_rsp_outstanding: assert property (@(posedge clock) disable iff (!rst_n_i)
		data_rsp_valid_i |-> req_sent_q);

	a_req_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		data_req_valid_o && !data_req_ready_i |=> data_req_valid_o && $stable(data_req_o));

endmodule

//--- hdl/rv_cpu.sv
`timescale 1ns/100ps
module rv_cpu #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic                  clock,
	input  logic                  rst_n_i,
	// instruction port
	output logic                  inst_req_valid_o,
	output logic [31:0]           inst_addr_o,
	input  logic                  inst_req_ready_i,
	input  logic                  inst_rsp_valid_i,
	input  logic [31:0]           inst_rdata_i,
	// data port
	output logic                  data_req_valid_o,
	output rv_core_pkg::mem_req_t data_req_o,
	input  logic                  data_req_ready_i,
	input  logic                  data_rsp_valid_i,
	input  logic [31:0]           data_rdata_i,
	output logic                  halt_o
);
	import rv_core_pkg::*;

	logic      fs_to_ds_valid;
	fs_to_ds_t fs_to_ds_bus;
	logic      ds_allowin;
	logic      ds_to_es_valid;
	ds_to_es_t ds_to_es_bus;
	logic      es_allowin;
	logic      es_to_ms_valid;
	es_to_ms_t es_to_ms_bus;
	logic      ms_allowin;
	dest_t     es_dest;
	dest_t     ms_dest;
	wb_t       wb;
	redirect_t redirect;

	rv_ifu_stage #(
		.RESET_PC (RESET_PC)
	) u_ifu (
		.clock            (clock            ),
		.rst_n_i          (rst_n_i          ),
		.redirect_i       (redirect         ),
		.halt_i           (halt_o           ),
		.ds_allowin_i     (ds_allowin       ),
		.fs_to_ds_valid_o (fs_to_ds_valid   ),
		.fs_to_ds_bus_o   (fs_to_ds_bus     ),
		.inst_req_valid_o (inst_req_valid_o ),
		.inst_addr_o      (inst_addr_o      ),
		.inst_req_ready_i (inst_req_ready_i ),
		.inst_rsp_valid_i (inst_rsp_valid_i ),
		.inst_rdata_i     (inst_rdata_i     )
	);

	rv_idu_stage u_idu (
		.clock            (clock          ),
		.rst_n_i          (rst_n_i        ),
		.fs_to_ds_valid_i (fs_to_ds_valid ),
		.fs_to_ds_bus_i   (fs_to_ds_bus   ),
		.ds_allowin_o     (ds_allowin     ),
		.ds_to_es_valid_o (ds_to_es_valid ),
		.ds_to_es_bus_o   (ds_to_es_bus   ),
		.es_allowin_i     (es_allowin     ),
		.es_dest_i        (es_dest        ),
		.ms_dest_i        (ms_dest        ),
		.wb_i             (wb             ),
		.redirect_i       (redirect       )
	);

	rv_exu_stage u_exu (
		.clock            (clock          ),
		.rst_n_i          (rst_n_i        ),
		.ds_to_es_valid_i (ds_to_es_valid ),
		.ds_to_es_bus_i   (ds_to_es_bus   ),
		.es_allowin_o     (es_allowin     ),
		.ms_allowin_i     (ms_allowin     ),
		.es_to_ms_valid_o (es_to_ms_valid ),
		.es_to_ms_bus_o   (es_to_ms_bus   ),
		.es_dest_o        (es_dest        ),
		.redirect_o       (redirect       )
	);

	rv_lsu_stage u_lsu (
		.clock            (clock            ),
		.rst_n_i          (rst_n_i          ),
		.es_to_ms_valid_i (es_to_ms_valid   ),
		.es_to_ms_bus_i   (es_to_ms_bus     ),
		.ms_allowin_o     (ms_allowin       ),
		.ms_dest_o        (ms_dest          ),
		.wb_o             (wb               ),
		.data_req_valid_o (data_req_valid_o ),
		.data_req_o       (data_req_o       ),
		.data_req_ready_i (data_req_ready_i ),
		.data_rsp_valid_i (data_rsp_valid_i ),
		.data_rdata_i     (data_rdata_i     ),
		.halt_o           (halt_o           )
	);

endmodule

//--- testbench/tb_rv_cpu.sv
`timescale 1ns/100ps
module tb_rv_cpu;
	import rv_core_pkg::*;

	localparam logic [31:0] RESET_PC = 32'h0;
	localparam logic [31:0] SEED = 32'ha493bcf1;
	localparam logic [31:0] SENTINEL = 32'h0000_01fc;
	localparam logic [6:0]  OP_IMM = 7'b0010011;
	localparam logic [6:0]  OP_LOAD = 7'b0000011;
	localparam int PROGRAM_LEN = 25;
	localparam int TIMEOUT_CYCLES = PROGRAM_LEN * 40 + 50;
	localparam int STORE_COUNT = 7;

	// expected stores in program order
	localparam logic [31:0] EXP_ADDR [STORE_COUNT] = '{
		32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114, 32'h118
	};
	localparam logic [31:0] EXP_DATA [STORE_COUNT] = '{
		32'h1234_5678, 32'h1234_5768, 32'hedcb_aa78, 32'h0000_0278,
		32'h0000_02f8, 32'hc0de_0045, 32'h0000_0054
	};

	logic        clock = 1'b0;
	logic        rst_n_i = 1'b1;
	logic        inst_req_valid;
	logic [31:0] inst_addr;
	logic        inst_req_ready = 1'b0;
	logic        inst_rsp_valid = 1'b0;
	logic [31:0] inst_rdata = '0;
	logic        data_req_valid;
	mem_req_t    data_req;
	logic        data_req_ready = 1'b0;
	logic        data_rsp_valid = 1'b0;
	logic [31:0] data_rdata = '0;
	logic        halt;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:127];
	logic        inst_fire;
	logic        data_fire;
	logic        inst_acc = 1'b0;
	logic [31:0] inst_acc_addr = '0;
	logic        data_acc = 1'b0;
	mem_req_t    data_acc_req = '0;
	logic        inst_busy = 1'b0;
	int          inst_wait = 0;
	logic        data_busy = 1'b0;
	int          data_wait = 0;
	logic        fetch_seen = 1'b0;
	int          store_count = 0;
	int          cycles = 0;

	rv_cpu #(
		.RESET_PC (RESET_PC)
	) u_rv_cpu (
		.clock            (clock          ),
		.rst_n_i          (rst_n_i        ),
		.inst_req_valid_o (inst_req_valid ),
		.inst_addr_o      (inst_addr      ),
		.inst_req_ready_i (inst_req_ready ),
		.inst_rsp_valid_i (inst_rsp_valid ),
		.inst_rdata_i     (inst_rdata     ),
		.data_req_valid_o (data_req_valid ),
		.data_req_o       (data_req       ),
		.data_req_ready_i (data_req_ready ),
		.data_rsp_valid_i (data_rsp_valid ),
		.data_rdata_i     (data_rdata     ),
		.halt_o           (halt           )
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic load_program();
		// spare words are nops carrying their own address
		for (int i = 0; i < 64; i++) begin
			imem[i] = i_type(12'(i * 4), 5'd0, 3'b000, 5'd0, OP_IMM);
		end
		// lui/addi chain, then add, sub, and, or on dependent registers
		imem[0] = u_type(20'h12345, 5'd1);
		imem[1] = i_type(12'h678, 5'd1, 3'b000, 5'd1, OP_IMM);
		imem[2] = s_type(12'h100, 5'd1, 5'd0);
		imem[3] = i_type(12'h0f0, 5'd0, 3'b000, 5'd2, OP_IMM);
		imem[4] = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
		imem[5] = s_type(12'h104, 5'd3, 5'd0);
		imem[6] = r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);
		imem[7] = s_type(12'h108, 5'd4, 5'd0);
		imem[8] = r_type(7'h00, 5'd1, 5'd4, 3'b111, 5'd5);
		imem[9] = r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6);
		imem[10] = s_type(12'h10c, 5'd5, 5'd0);
		imem[11] = s_type(12'h110, 5'd6, 5'd0);
		// load-use with lw x7 then addi x8 and sw x8
		imem[12] = i_type(12'h040, 5'd0, 3'b010, 5'd7, OP_LOAD);
		imem[13] = i_type(12'h005, 5'd7, 3'b000, 5'd8, OP_IMM);
		imem[14] = s_type(12'h114, 5'd8, 5'd0);
		// beq bne and jal each skip one store to the sentinel
		imem[15] = i_type(12'h001, 5'd0, 3'b000, 5'd9, OP_IMM);
		imem[16] = b_type(13'd8, 5'd9, 5'd9, 3'b000);
		imem[17] = s_type(SENTINEL[11:0], 5'd9, 5'd0);
		imem[18] = b_type(13'd8, 5'd0, 5'd9, 3'b001);
		imem[19] = s_type(SENTINEL[11:0], 5'd9, 5'd0);
		imem[20] = j_type(21'd8, 5'd10);
		imem[21] = s_type(SENTINEL[11:0], 5'd9, 5'd0);
		imem[22] = s_type(12'h118, 5'd10, 5'd0);
		imem[23] = 32'h0010_0073;
		imem[24] = s_type(SENTINEL[11:0], 5'd9, 5'd0);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation aborted");
	endtask

	assign inst_fire = inst_req_valid && inst_req_ready;
	assign data_fire = data_req_valid && data_req_ready;

	// handshakes as the DUT saw them at the rising edge
	always @(posedge clock) begin
		inst_acc <= inst_fire;
		data_acc <= data_fire;
		if (inst_fire) begin
			inst_acc_addr <= inst_addr;
		end
		if (data_fire) begin
			data_acc_req <= data_req;
		end
		if (!rst_n_i) begin
			fetch_seen <= 1'b0;
			store_count <= 0;
		end else begin
			if (inst_fire) begin
				fetch_seen <= 1'b1;
			end
			if (data_fire && data_req.we) begin
				store_count <= store_count + 1;
			end
		end
	end

	// instruction memory with random ready and 0 to 3 cycles of latency
	always @(negedge clock) begin
		if (!rst_n_i) begin
			load_program();
			inst_req_ready <= 1'b0;
			inst_rsp_valid <= 1'b0;
			inst_busy = 1'b0;
		end else begin
			inst_rsp_valid <= 1'b0;
			if (inst_acc) begin
				inst_busy = 1'b1;
				inst_wait = $urandom % 4;
				inst_req_ready <= 1'b0;
			end
			if (inst_busy && inst_wait == 0) begin
				inst_busy = 1'b0;
				inst_rsp_valid <= 1'b1;
				inst_rdata <= imem[inst_acc_addr[7:2]];
			end else if (inst_busy) begin
				inst_wait = inst_wait - 1;
			end
			if (!inst_busy) begin
				inst_req_ready <= ($urandom % 4) != 0;
			end
		end
	end

	// data memory with the same timing that also acknowledges stores
	always @(negedge clock) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 128; i++) begin
				dmem[i] = 32'hc0de_0000 | (i << 2);
			end
			data_req_ready <= 1'b0;
			data_rsp_valid <= 1'b0;
			data_busy = 1'b0;
		end else begin
			data_rsp_valid <= 1'b0;
			if (data_acc) begin
				if (data_acc_req.we) begin
					dmem[data_acc_req.addr[8:2]] = data_acc_req.wdata;
				end
				data_busy = 1'b1;
				data_wait = $urandom % 4;
				data_req_ready <= 1'b0;
			end
			if (data_busy && data_wait == 0) begin
				data_busy = 1'b0;
				data_rsp_valid <= 1'b1;
				data_rdata <= dmem[data_acc_req.addr[8:2]];
			end else if (data_busy) begin
				data_wait = data_wait - 1;
			end
			if (!data_busy) begin
				data_req_ready <= ($urandom % 4) != 0;
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: halt did not rise within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	a_quiet_in_reset: assert property (@(posedge clock)
		!rst_n_i |-> !inst_req_valid && !data_req_valid && !halt)
		else abort_run("a control output was active while reset was held");

	a_first_fetch: assert property (@(posedge clock) disable iff (!rst_n_i)
		inst_fire && !fetch_seen |-> inst_addr == RESET_PC)
		else abort_run($sformatf("MISMATCH at %0t: first fetch from %h, expected %h",
			$time, $sampled(inst_addr), RESET_PC));

	a_store_value: assert property (@(posedge clock) disable iff (!rst_n_i)
		data_fire && data_req.we && store_count < STORE_COUNT |->
			data_req.addr == EXP_ADDR[store_count] && data_req.wdata == EXP_DATA[store_count])
		else abort_run($sformatf("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
			$time, $sampled(store_count), $sampled(data_req.wdata), $sampled(data_req.addr),
			EXP_DATA[$sampled(store_count)], EXP_ADDR[$sampled(store_count)]));

	a_store_overrun: assert property (@(posedge clock) disable iff (!rst_n_i)
		data_fire && data_req.we |-> store_count < STORE_COUNT)
		else abort_run("more stores were accepted than the program performs");

	// wrong-path stores all target the sentinel
	a_no_sentinel: assert property (@(posedge clock) disable iff (!rst_n_i)
		data_fire && data_req.we |-> data_req.addr != SENTINEL)
		else abort_run("a store from a wrong-path instruction was accepted");

	a_halt_stores: assert property (@(posedge clock) disable iff (!rst_n_i)
		$rose(halt) |-> store_count == STORE_COUNT)
		else abort_run($sformatf("MISMATCH at %0t: %0d stores before halt, expected %0d",
			$time, $sampled(store_count), STORE_COUNT));

	a_no_fetch_after_halt: assert property (@(posedge clock) disable iff (!rst_n_i)
		halt |-> !inst_fire)
		else abort_run("an instruction request was accepted after halt");

	initial begin
		void'($urandom(SEED));
		#1;
		rst_n_i = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n_i <= 1'b1;
		while (!halt) begin
			@(negedge clock);
		end
		// watch a few cycles past halt for stray fetches
		repeat (8) @(negedge clock);
		if (store_count == STORE_COUNT) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run($sformatf("MISMATCH at %0t: %0d stores seen, expected %0d",
				$time, store_count, STORE_COUNT));
		end
	end

endmodule

//--- rv_cpu.f
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_regfile.sv
hdl/rv_ifu_stage.sv
hdl/rv_idu_stage.sv
hdl/rv_exu_stage.sv
hdl/rv_lsu_stage.sv
hdl/rv_cpu.sv
testbench/tb_rv_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_rv_cpu -f rv_cpu.f; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_rv_cpu)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if echo "$sim_out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
